// File: project.f
hw/tlb_pkg.sv
hw/tlb_bcast_if.sv
hw/tlb_cmd_ctrl.sv
hw/tlb_entry.sv
hw/tlb_hit_select.sv
hw/tlb_top.sv
tb/tb_clock.sv
tb/tb_tlb.sv

// File: Makefile
SRCS := $(wildcard hw/*.sv tb/*.sv)

obj_dir/Vtb_tlb: $(SRCS) project.f
	verilator --binary --timing --assert -j 0 --top-module tb_tlb -f project.f

run: obj_dir/Vtb_tlb
	./obj_dir/Vtb_tlb

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: tb/tb_tlb.sv
`timescale 1ns/10ps
`default_nettype none

module tb_tlb;

    import tlb_pkg::*;

    localparam int ACK_LAT     = 2;   // rising edges from driving req_i until ack_o is seen high
    localparam int ACK_WAIT    = 20;
    localparam int N_TRANS     = 313;
    localparam int CYCLE_LIMIT = 6 * N_TRANS + 100;
    localparam logic [9:0] SHARED_ASID = 10'h2a5;

    wire clk;
    wire rst_n;

    logic                 req;
    tlb_cmd_e             cmd;
    logic [TLB_IDX_W-1:0] index;
    tlb_cmd_data_u        data;

    wire                 ack;
    wire                 found;
    wire [TLB_IDX_W-1:0] hit_index;
    wire [5:0]           ps;
    wire [19:0]          ppn;
    wire                 v;
    wire                 d;
    wire [1:0]           mat;
    wire [1:0]           plv;

    tlb_entry_t           model [TLB_NUM];  // reference copy of every entry
    logic [31:0]          lfsr;
    int                   cycles = 0;
    logic                 got_found;
    logic [TLB_IDX_W-1:0] got_index;
    tlb_result_t          got_res;

    tb_clock tb_clock_i (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    tlb_top tlb_top_i (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .req_i       (req),
        .cmd_i       (cmd),
        .index_i     (index),
        .data_i      (data),
        .ack_o       (ack),
        .found_o     (found),
        .hit_index_o (hit_index),
        .ps_o        (ps),
        .ppn_o       (ppn),
        .v_o         (v),
        .d_o         (d),
        .mat_o       (mat),
        .plv_o       (plv)
    );

    // ####################################################################
    // error handling and compares
    // ####################################################################
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_found(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH %s: expected %0b, actual %0b", name, exp, act));
        end
    endtask

    task automatic check_index(input string name, input logic [TLB_IDX_W-1:0] exp,
                               input logic [TLB_IDX_W-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_result(input string name, input tlb_result_t exp, input tlb_result_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("MISMATCH %s ack latency: expected %0d, actual %0d",
                                name, exp, act));
        end
    endtask

    // Fibonacci LFSR over x^32 + x^22 + x^2 + x + 1 stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic tlb_page_t rand_page();
        tlb_page_t p;
        p.ppn = 20'(rand_bits(20));
        p.plv = 2'(rand_bits(2));
        p.mat = 2'(rand_bits(2));
        p.d   = 1'(rand_bits(1));
        p.v   = 1'(rand_bits(1));
        return p;
    endfunction

    // the index sits in the top vppn bits so no two entries ever overlap
    function automatic tlb_entry_t small_entry(input int idx, input logic g,
                                               input logic [9:0] asid);
        tlb_entry_t ent;
        ent.vppn = (19'(idx) << (19 - TLB_IDX_W)) | 19'(rand_bits(19 - TLB_IDX_W));
        ent.asid = asid;
        ent.g    = g;
        ent.ps   = PS_SMALL;
        ent.e    = 1'b1;
        ent.even = rand_page();
        ent.odd  = rand_page();
        return ent;
    endfunction

    function automatic logic vpn_hits(input tlb_entry_t ent, input logic [18:0] vppn);
        if (ent.ps == PS_HUGE) begin
            return vppn[18:10] == ent.vppn[18:10];
        end
        return vppn == ent.vppn;
    endfunction

    function automatic void expect_lookup(input tlb_search_t s, output logic exp_found,
                                          output logic [TLB_IDX_W-1:0] exp_index,
                                          output tlb_result_t exp_res);
        logic odd_half;
        exp_found = 1'b0;
        exp_index = '0;
        exp_res   = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            if (model[i].e && vpn_hits(model[i], s.vppn) &&
                (model[i].g || model[i].asid == s.asid)) begin
                odd_half     = (model[i].ps == PS_HUGE) ? s.vppn[9] : s.odd;
                exp_found    = 1'b1;
                exp_index    = TLB_IDX_W'(i);
                exp_res.ps   = model[i].ps;
                exp_res.page = odd_half ? model[i].odd : model[i].even;
            end
        end
    endfunction

    function automatic void apply_inv(input tlb_inv_t iv);
        logic kill;
        logic asid_eq;
        for (int i = 0; i < TLB_NUM; i++) begin
            asid_eq = (model[i].asid == iv.asid);
            case (iv.op)
                5'd0, 5'd1: kill = 1'b1;
                5'd2:       kill = model[i].g;
                5'd3:       kill = !model[i].g;
                5'd4:       kill = !model[i].g && asid_eq;
                5'd5:       kill = !model[i].g && asid_eq && vpn_hits(model[i], iv.vpn);
                5'd6:       kill = (model[i].g || asid_eq) && vpn_hits(model[i], iv.vpn);
                default:    kill = 1'b0;
            endcase
            if (kill) begin
                model[i].e = 1'b0;
            end
        end
    endfunction

    // ####################################################################
    // transactions
    // ####################################################################
    // hold keeps req_i high past ack_o and offers a write that must be ignored
    task automatic do_cmd(input string name, input tlb_cmd_e kind,
                          input logic [TLB_IDX_W-1:0] idx, input tlb_cmd_data_u word,
                          input int hold);
        int   waited;
        logic acked;
        waited = 0;
        acked  = 1'b0;
        @(posedge clk);
        req   <= 1'b1;
        cmd   <= kind;
        index <= idx;
        data  <= word;
        while (!acked) begin
            @(posedge clk);
            waited++;
            @(negedge clk);
            acked = ack;
            if (!acked && waited >= ACK_WAIT) begin
                abort_run($sformatf("%s: ack_o did not rise after req_i", name));
            end
        end
        check_latency(name, ACK_LAT, waited);
        got_found = found;
        got_index = hit_index;
        got_res   = {ps, ppn, plv, mat, d, v};
        for (int i = 0; i < hold; i++) begin
            @(posedge clk);
            cmd  <= CMD_WRITE;
            data <= ~word;
            @(negedge clk);
            check_found({name, " held ack"}, 1'b1, ack);
            check_found({name, " held"}, got_found, found);
            check_index({name, " held"}, got_index, hit_index);
            check_result({name, " held"}, got_res, {ps, ppn, plv, mat, d, v});
        end
        @(posedge clk);
        req    <= 1'b0;
        waited = 0;
        while (acked) begin
            @(negedge clk);
            waited++;
            acked = ack;
            if (acked && waited >= ACK_WAIT) begin
                abort_run($sformatf("%s: ack_o stayed high after req_i fell", name));
            end
        end
    endtask

    task automatic write_entry(input string name, input logic [TLB_IDX_W-1:0] idx,
                               input tlb_entry_t ent);
        tlb_cmd_data_u word;
        word          = '0;
        word.wr.entry = ent;
        do_cmd(name, CMD_WRITE, idx, word, 0);
        model[idx] = ent;
    endtask

    task automatic invalidate(input string name, input logic [4:0] op, input logic [9:0] asid,
                              input logic [18:0] vpn);
        tlb_cmd_data_u word;
        word              = '0;
        word.inv.inv.op   = op;
        word.inv.inv.asid = asid;
        word.inv.inv.vpn  = vpn;
        do_cmd(name, CMD_INV, '0, word, 0);
        apply_inv(word.inv.inv);
    endtask

    task automatic lookup(input string name, input logic [18:0] vppn, input logic odd,
                          input logic [9:0] asid, input int hold);
        tlb_cmd_data_u        word;
        logic                 exp_found;
        logic [TLB_IDX_W-1:0] exp_index;
        tlb_result_t          exp_res;
        word                  = '0;
        word.lookup.srch.vppn = vppn;
        word.lookup.srch.odd  = odd;
        word.lookup.srch.asid = asid;
        expect_lookup(word.lookup.srch, exp_found, exp_index, exp_res);
        do_cmd(name, CMD_LOOKUP, '0, word, hold);
        check_found(name, exp_found, got_found);
        check_index(name, exp_index, got_index);
        check_result(name, exp_res, got_res);
    endtask

    // ####################################################################
    // directed tests
    // ####################################################################
    task automatic after_reset();
        for (int i = 0; i < 4; i++) begin
            lookup("after_reset", 19'(rand_bits(19)), 1'(rand_bits(1)), 10'(rand_bits(10)), 0);
        end
    endtask

    task automatic small_pages();
        for (int i = 0; i < TLB_NUM; i++) begin
            write_entry("small_pages write", TLB_IDX_W'(i),
                        small_entry(i, 1'(rand_bits(1)), 10'(rand_bits(10))));
        end
        for (int i = 0; i < TLB_NUM; i++) begin
            lookup("small_pages even", model[i].vppn, 1'b0, model[i].asid, 0);
            lookup("small_pages odd", model[i].vppn, 1'b1, model[i].asid, 0);
            lookup("small_pages other asid", model[i].vppn, 1'b0, model[i].asid ^ 10'h001, 0);
        end
    endtask

    task automatic huge_pages();
        tlb_entry_t  ent;
        logic [18:0] va;
        int          k;
        for (int n = 0; n < 2; n++) begin
            k      = 3 + 6 * n;
            ent    = small_entry(k, 1'b0, 10'(rand_bits(10)));
            ent.ps = PS_HUGE;
            write_entry("huge_pages write", TLB_IDX_W'(k), ent);
            for (int b = 0; b < 4; b++) begin
                va    = {ent.vppn[18:10], 10'(rand_bits(10))};
                va[9] = b[0];  // vppn bit 9 picks the half and the odd bit is ignored
                lookup("huge_pages", va, b[1], ent.asid, 0);
            end
        end
    endtask

    task automatic inv_ops();
        logic [18:0] vpn;
        for (int op = 2; op <= 7; op++) begin
            for (int i = 0; i < TLB_NUM; i++) begin
                write_entry("inv_ops fill", TLB_IDX_W'(i),
                            small_entry(i, i % 3 == 0,
                                        (i % 2 == 0) ? SHARED_ASID : 10'(rand_bits(10))));
            end
            vpn = (op == 5) ? model[4].vppn : model[6].vppn;
            invalidate($sformatf("inv_ops op %0d", op), 5'(op), SHARED_ASID, vpn);
            for (int i = 0; i < TLB_NUM; i++) begin
                lookup($sformatf("inv_ops op %0d", op), model[i].vppn, 1'b0, model[i].asid, 0);
            end
        end
    endtask

    task automatic flush_all();
        invalidate("flush_all", 5'd0, '0, '0);
        for (int i = 0; i < TLB_NUM; i++) begin
            lookup("flush_all empty", model[i].vppn, 1'b0, model[i].asid, 0);
        end
        write_entry("flush_all rewrite", TLB_IDX_W'(5),
                    small_entry(5, 1'b0, 10'(rand_bits(10))));
        for (int i = 0; i < TLB_NUM; i++) begin
            lookup("flush_all one entry", model[i].vppn, 1'b1, model[i].asid, 0);
        end
    endtask

    // the ignored write would land on index 0 and break the second lookup
    task automatic held_request();
        write_entry("held_request write", '0, small_entry(0, 1'b0, 10'(rand_bits(10))));
        lookup("held_request", model[0].vppn, 1'b1, model[0].asid, 5);
        lookup("held_request after", model[0].vppn, 1'b0, model[0].asid, 0);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            abort_run($sformatf("the run passed its limit of %0d cycles", CYCLE_LIMIT));
        end
    end

    initial begin
        req   <= 1'b0;
        cmd   <= CMD_LOOKUP;
        index <= '0;
        data  <= '0;
        lfsr  = 32'h3e0e_fac3;
        for (int i = 0; i < TLB_NUM; i++) begin
            model[i] = '0;
        end
        @(posedge rst_n);
        after_reset();
        small_pages();
        huge_pages();
        inv_ops();
        flush_all();
        held_request();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int RESET_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever begin
            #50 clk_o = ~clk_o;  // 100 ns period
        end
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// File: hw/tlb_top.sv
`timescale 1ns/10ps
`default_nettype none

module tlb_top (
    input  wire                           clk,
    input  wire                           rst_n_i,
    input  wire                           req_i,
    input  wire tlb_pkg::tlb_cmd_e        cmd_i,
    input  wire [tlb_pkg::TLB_IDX_W-1:0]  index_i,
    input  wire tlb_pkg::tlb_cmd_data_u   data_i,
    output logic                          ack_o,
    output logic                          found_o,
    output logic [tlb_pkg::TLB_IDX_W-1:0] hit_index_o,
    output logic [5:0]                    ps_o,
    output logic [19:0]                   ppn_o,
    output logic                          v_o,
    output logic                          d_o,
    output logic [1:0]                    mat_o,
    output logic [1:0]                    plv_o
);

    import tlb_pkg::*;

    tlb_bcast_if bcast ();

    logic [TLB_NUM-1:0] entry_hit;
    tlb_result_t        entry_res [TLB_NUM];
    tlb_result_t        sel_res;

    tlb_cmd_ctrl tlb_cmd_ctrl_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (req_i),
        .cmd_i   (cmd_i),
        .index_i (index_i),
        .data_i  (data_i),
        .ack_o   (ack_o),
        .bus     (bcast.ctrl)
    );

    for (genvar n = 0; n < TLB_NUM; n++) begin : g_entry
        tlb_entry #(
            .IDX (TLB_IDX_W'(n))
        ) tlb_entry_i (
            .clk      (clk),
            .rst_n_i  (rst_n_i),
            .bus      (bcast.entry),
            .hit_o    (entry_hit[n]),
            .result_o (entry_res[n])
        );
    end

    tlb_hit_select tlb_hit_select_i (
        .clk         (clk),
        .hit_i       (entry_hit),
        .result_i    (entry_res),
        .found_o     (found_o),
        .hit_index_o (hit_index_o),
        .result_o    (sel_res)
    );

    assign ps_o  = sel_res.ps;
    assign ppn_o = sel_res.page.ppn;
    assign v_o   = sel_res.page.v;
    assign d_o   = sel_res.page.d;
    assign mat_o = sel_res.page.mat;
    assign plv_o = sel_res.page.plv;

endmodule

`default_nettype wire

// File: hw/tlb_hit_select.sv
`timescale 1ns/10ps
`default_nettype none

module tlb_hit_select (
    input  wire                         clk,
    input  wire [tlb_pkg::TLB_NUM-1:0]  hit_i,
    input  wire tlb_pkg::tlb_result_t   result_i [tlb_pkg::TLB_NUM],
    output logic                        found_o,
    output logic [tlb_pkg::TLB_IDX_W-1:0] hit_index_o,
    output tlb_pkg::tlb_result_t        result_o
);

    import tlb_pkg::*;

    assign found_o = |hit_i;

    // with a single hit the OR of masked entries is that entry, with none it is zero
    always_comb begin
        logic [TLB_IDX_W-1:0] idx;
        tlb_result_t          res;

        idx = '0;
        res = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            if (hit_i[i]) begin
                idx = idx | TLB_IDX_W'(i);
            end
            res = res | ({$bits(tlb_result_t){hit_i[i]}} & result_i[i]);
        end
        hit_index_o = idx;
        result_o    = res;
    end

    // overlapping entries would mix two translations
    a_single_hit: assert property (
        @(posedge clk) $onehot0(hit_i)
    );

endmodule

`default_nettype wire

// File: hw/tlb_entry.sv
`timescale 1ns/10ps
`default_nettype none

module tlb_entry #(
    parameter logic [tlb_pkg::TLB_IDX_W-1:0] IDX = '0
) (
    input  wire                  clk,
    input  wire                  rst_n_i,
    tlb_bcast_if.entry           bus,
    output logic                 hit_o,
    output tlb_pkg::tlb_result_t result_o
);

    import tlb_pkg::*;

    logic [18:0] vppn_q;
    logic [9:0]  asid_q;
    logic        g_q;
    logic [5:0]  ps_q;
    logic        e_q;
    tlb_page_t   even_q;
    tlb_page_t   odd_q;

    logic wr_hit;
    logic asid_hit;
    logic inv_kill;
    logic odd_sel;

    // a 4 MiB pair only compares the top nine vppn bits
    function automatic logic vpn_match(input logic [18:0] vppn);
        return (ps_q == PS_HUGE) ? (vppn[18:10] == vppn_q[18:10]) : (vppn == vppn_q);
    endfunction

    assign wr_hit   = bus.wr_en && (bus.wr_index == IDX);
    assign asid_hit = (asid_q == bus.inv.asid);
    assign odd_sel  = (ps_q == PS_SMALL) ? bus.srch.odd : bus.srch.vppn[9];

    always_comb begin
        case (bus.inv.op)
            5'd0, 5'd1: inv_kill = 1'b1;
            5'd2:       inv_kill = g_q;
            5'd3:       inv_kill = !g_q;
            5'd4:       inv_kill = !g_q && asid_hit;
            5'd5:       inv_kill = !g_q && asid_hit && vpn_match(bus.inv.vpn);
            5'd6:       inv_kill = (g_q || asid_hit) && vpn_match(bus.inv.vpn);
            default:    inv_kill = 1'b0;
        endcase
    end

    // write wins over invalidate
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            e_q <= 1'b0;
        end else if (wr_hit) begin
            e_q <= bus.wr_entry.e;
        end else if (bus.inv_en && inv_kill) begin
            e_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hit) begin
            vppn_q <= bus.wr_entry.vppn;
            asid_q <= bus.wr_entry.asid;
            g_q    <= bus.wr_entry.g;
            ps_q   <= bus.wr_entry.ps;
            even_q <= bus.wr_entry.even;
            odd_q  <= bus.wr_entry.odd;
        end
    end

    // ##################################################################
    // search result held until the next lookup
    // ##################################################################
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hit_o <= 1'b0;
        end else if (bus.srch_en) begin
            hit_o <= e_q && vpn_match(bus.srch.vppn) && (g_q || (asid_q == bus.srch.asid));
        end
    end

    always_ff @(posedge clk) begin
        if (bus.srch_en) begin
            result_o.ps   <= ps_q;
            result_o.page <= odd_sel ? odd_q : even_q;
        end
    end

endmodule

`default_nettype wire

// File: hw/tlb_cmd_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tlb_cmd_ctrl (
    input  wire                             clk,
    input  wire                             rst_n_i,
    input  wire                             req_i,
    input  wire tlb_pkg::tlb_cmd_e          cmd_i,
    input  wire [tlb_pkg::TLB_IDX_W-1:0]    index_i,
    input  wire tlb_pkg::tlb_cmd_data_u     data_i,
    output logic                            ack_o,
    tlb_bcast_if.ctrl                       bus
);

    import tlb_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_ISSUE = 2'd1,  // strobe is on the bus
        ST_ACK   = 2'd2
    } state_e;

    state_e state_q;
    logic   accept;

    assign accept = (state_q == ST_IDLE) && req_i;
    assign ack_o  = (state_q == ST_ACK);

    // ##################################################################
    // handshake FSM and strobes
    // ##################################################################
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= ST_IDLE;
            bus.srch_en <= 1'b0;
            bus.wr_en   <= 1'b0;
            bus.inv_en  <= 1'b0;
        end else begin
            bus.srch_en <= 1'b0;  // strobes last a single cycle
            bus.wr_en   <= 1'b0;
            bus.inv_en  <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (req_i) begin
                        state_q     <= ST_ISSUE;
                        bus.srch_en <= (cmd_i == CMD_LOOKUP);
                        bus.wr_en   <= (cmd_i == CMD_WRITE);
                        bus.inv_en  <= (cmd_i == CMD_INV);
                    end
                end
                ST_ISSUE: begin
                    state_q <= ST_ACK;  // entries capture on this edge
                end
                ST_ACK: begin
                    if (!req_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // every view of the word is latched and the strobe tells the entries which one counts
    always_ff @(posedge clk) begin
        if (accept) begin
            bus.srch     <= data_i.lookup.srch;
            bus.wr_index <= index_i;
            bus.wr_entry <= data_i.wr.entry;
            bus.inv      <= data_i.inv.inv;
        end
    end

    // ##################################################################
    // checks
    // ##################################################################
    a_req_held: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (state_q == ST_ISSUE) |-> req_i
    );

    // an unknown command kind would leave every strobe low
    a_one_strobe: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (state_q == ST_ISSUE) |-> $onehot({bus.srch_en, bus.wr_en, bus.inv_en})
    );

endmodule

`default_nettype wire

// File: hw/tlb_bcast_if.sv
`timescale 1ns/10ps
`default_nettype none

interface tlb_bcast_if;

    import tlb_pkg::*;

    // lookup
    logic        srch_en;
    tlb_search_t srch;

    // only the entry whose index matches takes a write
    logic                 wr_en;
    logic [TLB_IDX_W-1:0] wr_index;
    tlb_entry_t           wr_entry;

    // invalidate
    logic     inv_en;
    tlb_inv_t inv;

    modport ctrl (
        output srch_en,
        output srch,
        output wr_en,
        output wr_index,
        output wr_entry,
        output inv_en,
        output inv
    );

    modport entry (
        input srch_en,
        input srch,
        input wr_en,
        input wr_index,
        input wr_entry,
        input inv_en,
        input inv
    );

endinterface

`default_nettype wire

// File: hw/tlb_pkg.sv
`default_nettype none

package tlb_pkg;

    // ##################################################################
    // sizes
    // ##################################################################
    localparam int unsigned TLB_NUM   = 16;
    localparam int unsigned TLB_IDX_W = $clog2(TLB_NUM);

    localparam logic [5:0] PS_SMALL = 6'd12;  // 4 KiB page
    localparam logic [5:0] PS_HUGE  = 6'd22;  // 4 MiB page pair

    localparam int unsigned CMD_DATA_W = 91;

    typedef enum logic [1:0] {
        CMD_LOOKUP = 2'd0,
        CMD_WRITE  = 2'd1,
        CMD_INV    = 2'd2
    } tlb_cmd_e;

    // ##################################################################
    // entry and command fields
    // ##################################################################
    typedef struct packed {
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
    } tlb_page_t;

    typedef struct packed {
        logic [18:0] vppn;
        logic [9:0]  asid;
        logic        g;
        logic [5:0]  ps;
        logic        e;
        tlb_page_t   even;
        tlb_page_t   odd;
    } tlb_entry_t;

    typedef struct packed {
        logic [18:0] vppn;
        logic        odd;
        logic [9:0]  asid;
    } tlb_search_t;

    typedef struct packed {
        logic [4:0]  op;
        logic [9:0]  asid;
        logic [18:0] vpn;
    } tlb_inv_t;

    // each view of the command word is padded at the top to CMD_DATA_W
    typedef struct packed {
        logic [CMD_DATA_W-$bits(tlb_entry_t)-1:0] pad;
        tlb_entry_t                               entry;
    } tlb_wr_view_t;

    typedef struct packed {
        logic [CMD_DATA_W-$bits(tlb_search_t)-1:0] pad;
        tlb_search_t                               srch;
    } tlb_srch_view_t;

    typedef struct packed {
        logic [CMD_DATA_W-$bits(tlb_inv_t)-1:0] pad;
        tlb_inv_t                               inv;
    } tlb_inv_view_t;

    typedef union packed {
        tlb_wr_view_t   wr;
        tlb_srch_view_t lookup;
        tlb_inv_view_t  inv;
    } tlb_cmd_data_u;

    typedef struct packed {
        logic [5:0] ps;
        tlb_page_t  page;
    } tlb_result_t;

endpackage

`default_nettype wire
